/* logic/axi_mon_bus_pkg.sv */
/*
 * AXI read bus definitions for the passive read monitor.
 * Field widths, the snooped address and data beats, and response codes.
 */

package axi_mon_bus_pkg;

        // --------------------
        // Field widths
        // --------------------
        localparam int ID_W    = 8;
        localparam int ADDR_W  = 32;
        localparam int LEN_W   = 8;
        localparam int SIZE_W  = 3;
        localparam int BURST_W = 2;
        localparam int RESP_W  = 2;

        // Response codes that count as errors
        localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;
        localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

        // --------------------
        // Snooped channel beats
        // --------------------

        // Read address channel, sampled on the cmd handshake
        typedef struct packed {
                logic [ID_W-1:0]    id;
                logic [ADDR_W-1:0]  addr;
                logic [LEN_W-1:0]   len;
                logic [SIZE_W-1:0]  size;
                logic [BURST_W-1:0] burst;
        } cmd_beat_t;

        // Read data channel, payload itself is not tracked
        typedef struct packed {
                logic [ID_W-1:0]   id;
                logic              last;
                logic [RESP_W-1:0] resp;
        } data_beat_t;

endpackage

/* logic/axi_mon_trans_pkg.sv */
/*
 * Transaction tracking definitions for the AXI read monitor.
 * Table size, entry states, event codes, table entry and event packet.
 */

package axi_mon_trans_pkg;

        import axi_mon_bus_pkg::*;

        // --------------------
        // Table sizing
        // --------------------
        localparam int MAX_TRANS = 16;
        localparam int IDX_W     = $clog2(MAX_TRANS);
        // Active count must reach MAX_TRANS itself
        localparam int CNT_W     = $clog2(MAX_TRANS + 1);
        localparam int TS_W      = 32;
        // Beat counter, one bit wider than len so len+1 fits
        localparam int BEAT_W    = LEN_W + 1;

        // --------------------
        // Encodings
        // --------------------

        // FREE must stay zero, reset clears the table to FREE
        typedef enum logic [1:0] {
                ST_FREE   = 2'd0,
                ST_DATA   = 2'd1,
                ST_DONE   = 2'd2,
                ST_ORPHAN = 2'd3
        } trans_state_t;

        typedef enum logic [2:0] {
                EVT_OK      = 3'd0,
                EVT_SLVERR  = 3'd1,
                EVT_DECERR  = 3'd2,
                EVT_LEN_ERR = 3'd3,
                EVT_ORPHAN  = 3'd4
        } evt_code_t;

        // --------------------
        // Table and event types
        // --------------------

        // err_code is sticky while open and holds the final code once finished
        typedef struct packed {
                trans_state_t      state;
                logic [ID_W-1:0]   id;
                logic [ADDR_W-1:0] addr;
                logic [BEAT_W-1:0] exp_beats;
                logic [BEAT_W-1:0] beat_cnt;
                logic [TS_W-1:0]   start_ts;
                logic [TS_W-1:0]   latency;
                evt_code_t         err_code;
                logic              reported;
        } trans_entry_t;

        typedef struct packed {
                evt_code_t         code;
                logic [ID_W-1:0]   id;
                logic [ADDR_W-1:0] addr;
                logic [BEAT_W-1:0] beats;
                logic [TS_W-1:0]   latency;
        } evt_pkt_t;

        typedef trans_entry_t [MAX_TRANS-1:0] trans_table_t;

endpackage

/* logic/id_lookup.sv */
/*
 * Transaction table lookup.
 * Finds the lowest open entry for an ID and the lowest free entry.
 */

`timescale 1ns/1ps

module id_lookup
        import axi_mon_bus_pkg::*;
        import axi_mon_trans_pkg::*;
(
        input  trans_table_t     tbl,
        input  logic [ID_W-1:0]  id,
        output logic             hit,
        output logic [IDX_W-1:0] hit_idx,
        output logic             free,
        output logic [IDX_W-1:0] free_idx
);

        always_comb begin
                hit      = 1'b0;
                hit_idx  = '0;
                free     = 1'b0;
                free_idx = '0;

                // Lowest index wins in both searches
                for (int i = 0; i < MAX_TRANS; i++) begin
                        // Only entries still waiting for data count as open
                        if (!hit && tbl[i].state == ST_DATA && tbl[i].id == id) begin
                                hit     = 1'b1;
                                hit_idx = IDX_W'(i);
                        end
                        if (!free && tbl[i].state == ST_FREE) begin
                                free     = 1'b1;
                                free_idx = IDX_W'(i);
                        end
                end
        end

endmodule

/* logic/trans_table.sv */
/*
 * Read transaction table.
 * Opens entries on address handshakes, counts data beats, finalises the
 * event code on the last beat and frees entries once they are reported.
 */

`timescale 1ns/1ps

module trans_table
        import axi_mon_bus_pkg::*;
        import axi_mon_trans_pkg::*;
(
        input  logic                 aclk,
        input  logic                 arst_n,
        input  logic                 cmd_valid,
        input  logic                 cmd_ready,
        input  cmd_beat_t            cmd,
        input  logic                 data_valid,
        input  logic                 data_ready,
        input  data_beat_t           data,
        input  logic [MAX_TRANS-1:0] reported,
        output trans_table_t         tbl,
        output logic [CNT_W-1:0]     active_count
);

        trans_table_t      tbl_q;
        trans_table_t      data_view;
        logic [TS_W-1:0]   ts_q;
        logic [CNT_W-1:0]  count_q;
        logic [CNT_W-1:0]  n_freed;

        logic              cmd_hit;
        logic              cmd_free;
        logic [IDX_W-1:0]  cmd_free_idx;
        logic              data_hit;
        logic [IDX_W-1:0]  data_hit_idx;
        logic              data_free;
        logic [IDX_W-1:0]  data_free_idx;

        logic              cmd_create;
        logic              data_update;
        logic              orphan_create;

        trans_entry_t      hit_entry;
        logic [BEAT_W-1:0] new_cnt;
        evt_code_t         beat_err;
        evt_code_t         sticky_err;
        evt_code_t         final_code;

        // --------------------
        // Lookups
        // --------------------
        id_lookup cmd_lookup (
                .tbl      (tbl_q),
                .id       (cmd.id),
                .hit      (cmd_hit),
                .hit_idx  (),
                .free     (cmd_free),
                .free_idx (cmd_free_idx)
        );

        // Slot claimed by an address beat this cycle is hidden from the data side
        always_comb begin
                data_view = tbl_q;
                if (cmd_create) begin
                        data_view[cmd_free_idx].state = ST_DONE;
                end
        end

        id_lookup data_lookup (
                .tbl      (data_view),
                .id       (data.id),
                .hit      (data_hit),
                .hit_idx  (data_hit_idx),
                .free     (data_free),
                .free_idx (data_free_idx)
        );

        assign cmd_create    = cmd_valid && cmd_ready && !cmd_hit && cmd_free;
        assign data_update   = data_valid && data_ready && data_hit;
        assign orphan_create = data_valid && data_ready && !data_hit && data_free;

        // --------------------
        // Beat accounting
        // --------------------
        always_comb begin
                hit_entry = tbl_q[data_hit_idx];
                new_cnt   = hit_entry.beat_cnt + 1'b1;

                if (data.resp == RESP_DECERR) begin
                        beat_err = EVT_DECERR;
                end else if (data.resp == RESP_SLVERR) begin
                        beat_err = EVT_SLVERR;
                end else begin
                        beat_err = EVT_OK;
                end

                // First error seen stays
                sticky_err = (hit_entry.err_code != EVT_OK) ? hit_entry.err_code : beat_err;

                if (sticky_err != EVT_OK) begin
                        final_code = sticky_err;
                end else if (new_cnt != hit_entry.exp_beats) begin
                        final_code = EVT_LEN_ERR;
                end else begin
                        final_code = EVT_OK;
                end
        end

        // Entries flagged as reported last cycle leave the table now
        always_comb begin
                n_freed = '0;
                for (int i = 0; i < MAX_TRANS; i++) begin
                        if (tbl_q[i].reported) begin
                                n_freed = n_freed + 1'b1;
                        end
                end
        end

        // --------------------
        // Table update
        // --------------------
        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        tbl_q   <= '0;
                        ts_q    <= '0;
                        count_q <= '0;
                end else begin
                        ts_q    <= ts_q + 1'b1;
                        count_q <= count_q + CNT_W'(cmd_create) + CNT_W'(orphan_create) - n_freed;

                        // Two step cleanup: mark on handshake, free one cycle later
                        for (int i = 0; i < MAX_TRANS; i++) begin
                                if (tbl_q[i].reported) begin
                                        tbl_q[i].state    <= ST_FREE;
                                        tbl_q[i].reported <= 1'b0;
                                end else if (reported[i]) begin
                                        tbl_q[i].reported <= 1'b1;
                                end
                        end

                        if (cmd_create) begin
                                tbl_q[cmd_free_idx] <= '{
                                        state:     ST_DATA,
                                        id:        cmd.id,
                                        addr:      cmd.addr,
                                        exp_beats: BEAT_W'(cmd.len) + 1'b1,
                                        beat_cnt:  '0,
                                        start_ts:  ts_q,
                                        latency:   '0,
                                        err_code:  EVT_OK,
                                        reported:  1'b0
                                };
                        end

                        if (data_update) begin
                                tbl_q[data_hit_idx].beat_cnt <= new_cnt;
                                if (data.last) begin
                                        tbl_q[data_hit_idx].state    <= ST_DONE;
                                        tbl_q[data_hit_idx].latency  <= ts_q - hit_entry.start_ts;
                                        tbl_q[data_hit_idx].err_code <= final_code;
                                end else begin
                                        tbl_q[data_hit_idx].err_code <= sticky_err;
                                end
                        end else if (orphan_create) begin
                                // One orphan entry per unmatched beat
                                tbl_q[data_free_idx] <= '{
                                        state:     ST_ORPHAN,
                                        id:        data.id,
                                        addr:      '0,
                                        exp_beats: BEAT_W'(1),
                                        beat_cnt:  BEAT_W'(1),
                                        start_ts:  ts_q,
                                        latency:   '0,
                                        err_code:  EVT_ORPHAN,
                                        reported:  1'b0
                                };
                        end
                end
        end

        assign tbl          = tbl_q;
        assign active_count = count_q;

endmodule

/* logic/event_reporter.sv */
/*
 * Event reporter for the read monitor.
 * Picks finished entries round-robin, holds one packet under back-pressure
 * and flags the entry as reported on the handshake.
 */

`timescale 1ns/1ps

module event_reporter
        import axi_mon_trans_pkg::*;
(
        input  logic                 aclk,
        input  logic                 arst_n,
        input  trans_table_t         tbl,
        output logic                 evt_valid,
        input  logic                 evt_ready,
        output evt_pkt_t             evt,
        output logic [MAX_TRANS-1:0] reported
);

        logic [IDX_W-1:0] rr_ptr;
        logic [IDX_W-1:0] cur_idx;
        logic [IDX_W-1:0] pick_idx;
        logic             pick_vld;
        logic             evt_fire;
        logic             load;

        assign evt_fire = evt_valid && evt_ready;
        // New packet only when the output slot is empty or draining
        assign load     = pick_vld && (!evt_valid || evt_ready);

        // --------------------
        // Round-robin pick
        // --------------------
        always_comb begin
                logic [IDX_W-1:0] idx;

                pick_vld = 1'b0;
                pick_idx = '0;
                for (int off = 0; off < MAX_TRANS; off++) begin
                        // Index wraps through the IDX_W truncation
                        idx = rr_ptr + IDX_W'(off);
                        if (!pick_vld &&
                            (tbl[idx].state == ST_DONE || tbl[idx].state == ST_ORPHAN) &&
                            !tbl[idx].reported &&
                            !(evt_valid && idx == cur_idx)) begin
                                pick_vld = 1'b1;
                                pick_idx = idx;
                        end
                end
        end

        always_comb begin
                reported = '0;
                if (evt_fire) begin
                        reported[cur_idx] = 1'b1;
                end
        end

        // --------------------
        // Output stage
        // --------------------
        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        evt_valid <= 1'b0;
                        rr_ptr    <= '0;
                end else begin
                        if (load) begin
                                evt_valid <= 1'b1;
                        end else if (evt_fire) begin
                                evt_valid <= 1'b0;
                        end
                        if (evt_fire) begin
                                rr_ptr <= cur_idx + 1'b1;
                        end
                end
        end

        always_ff @(posedge aclk) begin
                if (load) begin
                        cur_idx <= pick_idx;
                        evt     <= '{
                                code:    tbl[pick_idx].err_code,
                                id:      tbl[pick_idx].id,
                                addr:    tbl[pick_idx].addr,
                                beats:   tbl[pick_idx].beat_cnt,
                                latency: tbl[pick_idx].latency
                        };
                end
        end

endmodule

/* logic/axi_rd_monitor.sv */
/*
 * Passive AXI read path monitor.
 * Tracks read bursts by ID and emits one event per finished transaction.
 */

`timescale 1ns/1ps

module axi_rd_monitor
        import axi_mon_bus_pkg::*;
        import axi_mon_trans_pkg::*;
(
        input  logic             aclk,
        input  logic             arst_n,
        input  logic             cmd_valid,
        input  logic             cmd_ready,
        input  cmd_beat_t        cmd,
        input  logic             data_valid,
        input  logic             data_ready,
        input  data_beat_t       data,
        output logic             evt_valid,
        input  logic             evt_ready,
        output evt_pkt_t         evt,
        output logic [CNT_W-1:0] active_count
);

        trans_table_t         tbl;
        logic [MAX_TRANS-1:0] reported;

        trans_table u_table (
                .aclk         (aclk),
                .arst_n       (arst_n),
                .cmd_valid    (cmd_valid),
                .cmd_ready    (cmd_ready),
                .cmd          (cmd),
                .data_valid   (data_valid),
                .data_ready   (data_ready),
                .data         (data),
                .reported     (reported),
                .tbl          (tbl),
                .active_count (active_count)
        );

        // Reporter feedback closes the loop for entry cleanup
        event_reporter u_reporter (
                .aclk      (aclk),
                .arst_n    (arst_n),
                .tbl       (tbl),
                .evt_valid (evt_valid),
                .evt_ready (evt_ready),
                .evt       (evt),
                .reported  (reported)
        );

endmodule

/* test/clk_gen.sv */
/*
 * Testbench clock and reset source.
 * 40 ns clock, reset held low for the first 4 cycles.
 */

`timescale 1ns/1ps

module clk_gen (
        output logic aclk,
        output logic arst_n
);

        initial begin
                aclk = 1'b0;
                forever #20 aclk = ~aclk;
        end

        initial begin
                arst_n = 1'b0;
                repeat (4) @(posedge aclk);
                arst_n <= 1'b1;
        end

endmodule

/* test/axi_rd_monitor_properties.sv */
/*
 * Concurrent checks on the monitor event stream and active count.
 * Bound into the monitor top level.
 */

`timescale 1ns/1ps

module axi_rd_monitor_properties
        import axi_mon_trans_pkg::*;
(
        input logic             aclk,
        input logic             arst_n,
        input logic             evt_valid,
        input logic             evt_ready,
        input evt_pkt_t         evt,
        input logic [CNT_W-1:0] active_count
);

        // Number of assertion failures so far
        int n_fail = 0;

        // Packet is frozen while the sink stalls
        a_evt_hold: assert property (@(posedge aclk) disable iff (!arst_n)
                evt_valid && !evt_ready |=> evt_valid && $stable(evt))
                else begin
                        n_fail++;
                        $error("event packet changed while stalled");
                end

        a_count_max: assert property (@(posedge aclk) disable iff (!arst_n)
                active_count <= CNT_W'(MAX_TRANS))
                else begin
                        n_fail++;
                        $error("active count above table size");
                end

        a_valid_known: assert property (@(posedge aclk) disable iff (!arst_n)
                !$isunknown(evt_valid))
                else begin
                        n_fail++;
                        $error("evt_valid unknown");
                end

endmodule

/* test/axi_rd_monitor_tb.sv */
/*
 * Testbench for the AXI read monitor.
 * Table of read transactions, queue model of expected events,
 * random event stalls and a cycle limit.
 */

`timescale 1ns/1ps

module axi_rd_monitor_tb
        import axi_mon_bus_pkg::*;
        import axi_mon_trans_pkg::*;
();

        localparam int N_ROWS = 29;

        // One transaction of the stimulus table
        typedef struct packed {
                int                grp;
                logic              send_cmd;
                logic [ID_W-1:0]   id;
                logic [ADDR_W-1:0] addr;
                logic [LEN_W-1:0]  len;
                int                beats;
                int                err_beat;
                logic [RESP_W-1:0] err_resp;
                logic              twice;
                int                gap;
                evt_code_t         code;
                int                lat;
        } row_t;

        logic             aclk;
        logic             arst_n;
        logic             cmd_valid;
        logic             cmd_ready;
        cmd_beat_t        cmd;
        logic             data_valid;
        logic             data_ready;
        data_beat_t       data;
        logic             evt_valid;
        logic             evt_ready;
        evt_pkt_t         evt;
        logic [CNT_W-1:0] active_count;

        row_t     rows [N_ROWS];
        int       cmd_cyc [N_ROWS];
        evt_pkt_t exp_q [$];
        int       cycle = 0;
        int       limit;
        int       seed_val;

        clk_gen u_clk (
                .aclk   (aclk),
                .arst_n (arst_n)
        );

        axi_rd_monitor UUT (
                .aclk         (aclk),
                .arst_n       (arst_n),
                .cmd_valid    (cmd_valid),
                .cmd_ready    (cmd_ready),
                .cmd          (cmd),
                .data_valid   (data_valid),
                .data_ready   (data_ready),
                .data         (data),
                .evt_valid    (evt_valid),
                .evt_ready    (evt_ready),
                .evt          (evt),
                .active_count (active_count)
        );

        bind axi_rd_monitor axi_rd_monitor_properties u_props (
                .aclk         (aclk),
                .arst_n       (arst_n),
                .evt_valid    (evt_valid),
                .evt_ready    (evt_ready),
                .evt          (evt),
                .active_count (active_count)
        );

        // --------------------
        // Failure and compare
        // --------------------
        task automatic fail_run(input string msg);
                $display("%s", msg);
                $display("Test failed");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check_evt(input evt_pkt_t got, input evt_pkt_t exp);
                string got_s;
                string exp_s;

                if (got !== exp) begin
                        got_s = $sformatf("code %0d addr %08h beats %0d lat %0d",
                                got.code, got.addr, got.beats, got.latency);
                        exp_s = $sformatf("code %0d addr %08h beats %0d lat %0d",
                                exp.code, exp.addr, exp.beats, exp.latency);
                        fail_run($sformatf("[ERROR] %0t: event id %02h got %s, expected %s",
                                $time, got.id, got_s, exp_s));
                end
        endtask

        task automatic check_count(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] exp);
                if (got !== exp) begin
                        fail_run($sformatf("[ERROR] %0t: active_count is %0d, expected %0d",
                                $time, got, exp));
                end
        endtask

        // Events may come out of order so they are matched on ID
        task automatic take_event(input evt_pkt_t got);
                int idx;

                idx = -1;
                for (int i = 0; i < exp_q.size(); i++) begin
                        if (idx < 0 && exp_q[i].id == got.id) begin
                                idx = i;
                        end
                end
                if (idx < 0) begin
                        fail_run($sformatf("An event for ID %02h arrived that no transaction explains",
                                got.id));
                end else begin
                        check_evt(got, exp_q[idx]);
                        exp_q.delete(idx);
                end
        endtask

        // --------------------
        // Stimulus table
        // --------------------
        task automatic build_table();
                // grp cmd id addr len beats err_beat err_resp twice gap code lat
                rows[0] = '{0, 1'b1, 8'h11, 32'h0000_1000, 8'd3, 4, -1, 2'b00, 1'b0, 0, EVT_OK, 5};
                rows[1] = '{1, 1'b1, 8'h22, 32'h0000_2040, 8'd0, 1, -1, 2'b00, 1'b0, 2, EVT_OK, 4};
                rows[2] = '{2, 1'b1, 8'h33, 32'h0000_3000, 8'd3, 4, 1, RESP_SLVERR, 1'b0, 1,
                            EVT_SLVERR, 6};
                rows[3] = '{3, 1'b1, 8'h44, 32'h0000_4000, 8'd2, 3, 0, RESP_DECERR, 1'b1, 0,
                            EVT_DECERR, 4};
                rows[4] = '{4, 1'b1, 8'h55, 32'h0000_5000, 8'd2, 3, 2, RESP_SLVERR, 1'b0, 0,
                            EVT_SLVERR, 4};
                rows[5] = '{5, 1'b1, 8'h66, 32'h0000_6000, 8'd3, 2, -1, 2'b00, 1'b0, 0,
                            EVT_LEN_ERR, 3};
                rows[6] = '{6, 1'b1, 8'h77, 32'h0000_7000, 8'd1, 5, -1, 2'b00, 1'b0, 0,
                            EVT_LEN_ERR, 6};
                rows[7] = '{7, 1'b0, 8'h99, 32'h0, 8'd0, 3, -1, 2'b00, 1'b0, 1, EVT_ORPHAN, 0};
                // Sixteen IDs fill the table and the seventeenth (0x90) is dropped
                for (int i = 0; i <= MAX_TRANS; i++) begin
                        rows[8+i] = '{8, 1'b1, ID_W'(8'h80 + i), ADDR_W'(32'h8000 + i * 256),
                                      LEN_W'(i % 4), (i < MAX_TRANS) ? (i % 4) + 1 : 0,
                                      -1, 2'b00, 1'b0, 0, EVT_OK, -1};
                end
                rows[25] = '{9, 1'b0, 8'h90, 32'h0, 8'd0, 2, -1, 2'b00, 1'b0, 0, EVT_ORPHAN, 0};
                // Interleaved group
                rows[26] = '{10, 1'b1, 8'hA1, 32'h0000_A100, 8'd1, 2, -1, 2'b00, 1'b0, 0,
                             EVT_OK, -1};
                rows[27] = '{10, 1'b1, 8'hA2, 32'h0000_A200, 8'd3, 4, 3, RESP_DECERR, 1'b0, 0,
                             EVT_DECERR, -1};
                rows[28] = '{10, 1'b1, 8'hA3, 32'h0000_A300, 8'd2, 3, -1, 2'b00, 1'b0, 0,
                             EVT_OK, -1};
        endtask

        // --------------------
        // Drivers and model
        // --------------------
        task automatic send_beat(input int i, input int r);
                logic [RESP_W-1:0] resp;
                evt_pkt_t          exp;

                resp = 2'b00;
                if (r == rows[i].err_beat) begin
                        resp = rows[i].err_resp;
                end else if (rows[i].twice && r == rows[i].err_beat + 1) begin
                        // Second error of the other kind must not override the first
                        resp = (rows[i].err_resp == RESP_SLVERR) ? RESP_DECERR : RESP_SLVERR;
                end
                data_valid <= 1'b1;
                data_ready <= 1'b1;
                data       <= '{id: rows[i].id, last: (r == rows[i].beats - 1), resp: resp};
                @(posedge aclk);

                if (!rows[i].send_cmd) begin
                        exp = '{code: EVT_ORPHAN, id: rows[i].id, addr: '0,
                                beats: BEAT_W'(1), latency: '0};
                        exp_q.push_back(exp);
                end else if (r == rows[i].beats - 1) begin
                        exp = '{code: rows[i].code, id: rows[i].id, addr: rows[i].addr,
                                beats: BEAT_W'(rows[i].beats),
                                latency: (rows[i].lat >= 0) ? TS_W'(rows[i].lat)
                                                            : TS_W'(cycle - cmd_cyc[i])};
                        exp_q.push_back(exp);
                end
        endtask

        // All commands of a group go first and then the data beats round-robin
        task automatic run_group(input int first, input int last);
                int n_cmd;
                int max_beats;

                n_cmd     = 0;
                max_beats = 0;
                @(posedge aclk);
                for (int i = first; i <= last; i++) begin
                        if (rows[i].send_cmd) begin
                                cmd_valid <= 1'b1;
                                cmd_ready <= 1'b1;
                                cmd       <= '{id: rows[i].id, addr: rows[i].addr,
                                               len: rows[i].len, size: 3'd2, burst: 2'b01};
                                @(posedge aclk);
                                cmd_cyc[i] = cycle;
                                n_cmd++;
                        end
                        if (rows[i].beats > max_beats) begin
                                max_beats = rows[i].beats;
                        end
                end
                cmd_valid <= 1'b0;
                cmd_ready <= 1'b0;

                // Table starts empty so only a full table drops commands
                @(negedge aclk);
                check_count(active_count, CNT_W'((n_cmd > MAX_TRANS) ? MAX_TRANS : n_cmd));
                @(posedge aclk);
                repeat (rows[first].gap) @(posedge aclk);

                for (int r = 0; r < max_beats; r++) begin
                        for (int i = first; i <= last; i++) begin
                                if (r < rows[i].beats) begin
                                        send_beat(i, r);
                                end
                        end
                end
                data_valid <= 1'b0;
                data_ready <= 1'b0;
        endtask

        task automatic wait_drain();
                while (exp_q.size() != 0) begin
                        @(posedge aclk);
                end
                // Entries leave the table one cycle after the handshake
                repeat (2) @(posedge aclk);
                @(negedge aclk);
                check_count(active_count, '0);
        endtask

        // --------------------
        // Sink, collector, limit
        // --------------------
        initial begin
                seed_val  = $urandom(32'h44d86072);
                evt_ready = 1'b0;
                forever begin
                        @(posedge aclk);
                        evt_ready <= ($urandom % 4) != 0;
                end
        end

        always @(negedge aclk) begin
                if (arst_n && evt_valid && evt_ready) begin
                        take_event(evt);
                end
        end

        // Bound assertions count their failures
        always @(negedge aclk) begin
                if (UUT.u_props.n_fail != 0) begin
                        fail_run("A bound assertion on the event stream or count failed");
                end
        end

        always @(posedge aclk) begin
                cycle <= cycle + 1;
                if (cycle >= limit) begin
                        fail_run($sformatf("Timeout: events still missing after %0d cycles",
                                limit));
                end
        end

        // --------------------
        // Main sequence
        // --------------------
        initial begin
                int first;
                int last;

                cmd_valid  = 1'b0;
                cmd_ready  = 1'b0;
                cmd        = '0;
                data_valid = 1'b0;
                data_ready = 1'b0;
                data       = '0;
                build_table();

                limit = 200;
                for (int i = 0; i < N_ROWS; i++) begin
                        limit += rows[i].gap + 8 * rows[i].beats + 8;
                end

                wait (arst_n === 1'b1);
                first = 0;
                while (first < N_ROWS) begin
                        last = first;
                        while (last + 1 < N_ROWS && rows[last+1].grp == rows[first].grp) begin
                                last++;
                        end
                        run_group(first, last);
                        wait_drain();
                        first = last + 1;
                end

                if (UUT.u_props.n_fail == 0) begin
                        $display("Test passed");
                        $finish;
                end else begin
                        fail_run($sformatf("%0d assertion failures on the event stream",
                                UUT.u_props.n_fail));
                end
        end

endmodule

/* axi_rd_monitor.f */
logic/axi_mon_bus_pkg.sv
logic/axi_mon_trans_pkg.sv
logic/id_lookup.sv
logic/trans_table.sv
logic/event_reporter.sv
logic/axi_rd_monitor.sv
test/clk_gen.sv
test/axi_rd_monitor_properties.sv
test/axi_rd_monitor_tb.sv

/* Bender.yml */
package:
  name: axi_rd_monitor

sources:
  - logic/axi_mon_bus_pkg.sv
  - logic/axi_mon_trans_pkg.sv
  - logic/id_lookup.sv
  - logic/trans_table.sv
  - logic/event_reporter.sv
  - logic/axi_rd_monitor.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/axi_rd_monitor_properties.sv
      - test/axi_rd_monitor_tb.sv
